// ==== afu.f ====
+incdir+hw
hw/host_if_pkg.sv
hw/dma_pkg.sv
hw/mmio_csr.sv
hw/host_rd_bridge.sv
hw/host_wr_bridge.sv
hw/copy_engine.sv
hw/afu.sv
tb/host_mem_model.sv
tb/tb_afu.sv

// ==== hw/afu.sv ====
// **********************************************************
// afu top level
// mmio csr block, host read and write bridges, copy engine
// **********************************************************
`timescale 1ns/10ps

module afu (
	input  logic                      clk,
	input  logic                      rst,
	input  host_if_pkg::mmio_req_t    mmio_req,
	output host_if_pkg::mmio_rsp_t    mmio_rsp,
	output host_if_pkg::host_rd_req_t host_rd_req,
	input  host_if_pkg::host_rd_rsp_t host_rd_rsp,
	input  logic                      rd_credit,
	output host_if_pkg::host_wr_req_t host_wr_req,
	input  host_if_pkg::host_wr_rsp_t host_wr_rsp,
	input  logic                      wr_credit
);

	dma_pkg::copy_desc_t     desc;              // csr to engine
	logic                    start;
	logic                    busy;
	logic                    done;
	dma_pkg::len_t           lines_done;
	logic                    rd_line_req_valid; // engine to read bridge
	host_if_pkg::line_addr_t rd_line_req_addr;
	logic                    rd_line_ready;
	logic                    rd_data_valid;
	host_if_pkg::line_t      rd_data;
	logic                    wr_line_req_valid; // engine to write bridge
	host_if_pkg::line_addr_t wr_line_req_addr;
	host_if_pkg::line_t      wr_line_req_data;
	logic                    wr_line_ready;
	logic                    irq_req;
	logic                    irq_ready;
	logic                    wr_ack;

	mmio_csr mmio_csr_inst (.*);       // names match one to one

	copy_engine copy_engine_inst (.*);

	host_rd_bridge host_rd_bridge_inst (
		.clk             (clk),
		.rst             (rst),
		.line_req_valid  (rd_line_req_valid),
		.line_req_addr   (rd_line_req_addr),
		.line_req_ready  (rd_line_ready),
		.line_data_valid (rd_data_valid),
		.line_data       (rd_data),
		.host_rd_req     (host_rd_req),
		.host_rd_rsp     (host_rd_rsp),
		.rd_credit       (rd_credit)
	);

	host_wr_bridge host_wr_bridge_inst (
		.clk             (clk),
		.rst             (rst),
		.line_req_valid  (wr_line_req_valid),
		.line_req_addr   (wr_line_req_addr),
		.line_req_data   (wr_line_req_data),
		.line_req_ready  (wr_line_ready),
		.irq_req         (irq_req),
		.irq_ready       (irq_ready),
		.ack             (wr_ack),          // interrupt acks filtered out
		.host_wr_req     (host_wr_req),
		.host_wr_rsp     (host_wr_rsp),
		.wr_credit       (wr_credit)
	);

endmodule

// ==== hw/afu_params.svh ====
// **********************************************************
// afu shell parameters
// line, address and tag widths, host credits, buffer depth
// **********************************************************
`ifndef AFU_PARAMS_SVH
`define AFU_PARAMS_SVH

`define AFU_LINE_W     64 // bits per cache line
`define AFU_ADDR_W     32 // line address, not byte address
`define AFU_TAG_W      6  // host request tag
`define AFU_LEN_W      16 // max lines per copy run

// request slots granted by the host after reset
`define AFU_RD_CREDITS 4
`define AFU_WR_CREDITS 4

`define AFU_BUF_DEPTH  8  // engine line buffer, power of two

`endif

// ==== hw/copy_engine.sv ====
// **********************************************************
// copy engine
// reads a run of lines from src, holds them in a small buffer,
// writes them to dst, then reports done and optional irq
// **********************************************************
`timescale 1ns/10ps
`include "afu_params.svh"

module copy_engine (
	input  logic                    clk,
	input  logic                    rst,
	input  dma_pkg::copy_desc_t     desc,
	input  logic                    start,
	output logic                    busy,
	output logic                    done,              // held until next start
	output dma_pkg::len_t           lines_done,
	output logic                    rd_line_req_valid,
	output host_if_pkg::line_addr_t rd_line_req_addr,
	input  logic                    rd_line_ready,
	input  logic                    rd_data_valid,
	input  host_if_pkg::line_t      rd_data,
	output logic                    wr_line_req_valid,
	output host_if_pkg::line_addr_t wr_line_req_addr,
	output host_if_pkg::line_t      wr_line_req_data,
	input  logic                    wr_line_ready,
	output logic                    irq_req,
	input  logic                    irq_ready,
	input  logic                    wr_ack
);

	localparam int PTR_W = $clog2(`AFU_BUF_DEPTH);
	typedef logic [PTR_W-1:0] ptr_t; // buffer slot
	typedef logic [PTR_W:0]   cnt_t; // 0..depth

	dma_pkg::copy_state_t state;
	dma_pkg::copy_desc_t  cur;                        // latched at go
	dma_pkg::len_t        rd_idx;                     // reads issued
	dma_pkg::len_t        wr_idx;                     // writes issued
	dma_pkg::len_t        ack_cnt;                    // writes acked
	cnt_t                 rd_out;                     // reads in flight
	cnt_t                 buf_cnt;                    // lines buffered
	ptr_t                 wp;
	ptr_t                 rp;
	host_if_pkg::line_t   line_buf [`AFU_BUF_DEPTH];
	logic                 rd_acc;
	logic                 wr_acc;
	logic                 room;                       // space for one more read

	assign busy              = state != dma_pkg::IDLE;
	assign lines_done        = ack_cnt;
	assign room              = (rd_out + buf_cnt) < cnt_t'(`AFU_BUF_DEPTH);
	assign rd_line_req_valid = state == dma_pkg::RUN && rd_idx != cur.len && room;
	assign rd_line_req_addr  = cur.src + host_if_pkg::line_addr_t'(rd_idx);
	assign rd_acc            = rd_line_req_valid & rd_line_ready;
	assign wr_line_req_valid = state == dma_pkg::RUN && buf_cnt != '0;
	assign wr_line_req_addr  = cur.dst + host_if_pkg::line_addr_t'(wr_idx); // same index
	assign wr_line_req_data  = line_buf[rp];
	assign wr_acc            = wr_line_req_valid & wr_line_ready;
	assign irq_req           = state == dma_pkg::NOTIFY && cur.irq_en;

	always_ff @(posedge clk) begin
		if (rd_data_valid)
			line_buf[wp] <= rd_data;
	end

	// **********************************************************
	// counters and descriptor FSM
	// **********************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= dma_pkg::IDLE;
			cur     <= '0;
			done    <= 1'b0;
			rd_idx  <= '0;
			wr_idx  <= '0;
			ack_cnt <= '0;
			rd_out  <= '0;
			buf_cnt <= '0;
			wp      <= '0;
			rp      <= '0;
		end else begin
			rd_out  <= rd_out + cnt_t'(rd_acc) - cnt_t'(rd_data_valid);
			buf_cnt <= buf_cnt + cnt_t'(rd_data_valid) - cnt_t'(wr_acc);
			if (rd_data_valid)
				wp <= wp + ptr_t'(1);
			if (wr_acc)
				rp <= rp + ptr_t'(1);
			if (rd_acc)
				rd_idx <= rd_idx + dma_pkg::len_t'(1);
			if (wr_acc)
				wr_idx <= wr_idx + dma_pkg::len_t'(1);
			if (wr_ack)
				ack_cnt <= ack_cnt + dma_pkg::len_t'(1);
			case (state)
				dma_pkg::IDLE: if (start) begin               // go ignored while busy
					cur     <= desc;
					rd_idx  <= '0;
					wr_idx  <= '0;
					ack_cnt <= '0;
					done    <= desc.len == '0;                 // empty run ends here
					state   <= (desc.len == '0) ? dma_pkg::IDLE : dma_pkg::RUN;
				end
				dma_pkg::RUN: if (wr_idx == cur.len)
					state <= dma_pkg::FINISH;                   // all writes issued
				dma_pkg::FINISH: if (ack_cnt == cur.len)
					state <= dma_pkg::NOTIFY;
				dma_pkg::NOTIFY: if (!cur.irq_en || irq_ready) begin
					done  <= 1'b1;
					state <= dma_pkg::IDLE;
				end
				default: state <= dma_pkg::IDLE;
			endcase
		end
	end

	// data only for reads in flight, and always room for it
	a_buf_no_overrun: assert property (@(posedge clk) disable iff (rst)
		rd_data_valid |-> rd_out != '0 && buf_cnt < cnt_t'(`AFU_BUF_DEPTH))
		else $error("read data with no room in line buffer");

endmodule

// ==== hw/dma_pkg.sv ====
// **********************************************************
// copy engine types
// csr map, descriptor and engine states
// **********************************************************
`include "afu_params.svh"

package dma_pkg;

	typedef enum logic [7:0] {
		CSR_SRC    = 8'h00, // source line address
		CSR_DST    = 8'h08, // destination line address
		CSR_LEN    = 8'h10, // lines to copy
		CSR_CTRL   = 8'h18, // bit0 go, bit1 irq enable
		CSR_STATUS = 8'h20  // busy, done, lines_done
	} csr_addr_t;

	typedef logic [63:0]           csr_data_t;
	typedef logic [`AFU_LEN_W-1:0] len_t;      // line count

	typedef struct packed {
		host_if_pkg::line_addr_t src;
		host_if_pkg::line_addr_t dst;
		len_t                    len;
		logic                    irq_en;      // send interrupt at end
	} copy_desc_t;

	typedef enum logic [1:0] {
		IDLE,   // waiting for go
		RUN,    // reads and writes in flight
		FINISH, // draining write acks
		NOTIFY  // interrupt out
	} copy_state_t;

endpackage

// ==== hw/host_if_pkg.sv ====
// **********************************************************
// host channel types
// mmio request/response plus credited read and write channels
// **********************************************************
`include "afu_params.svh"

package host_if_pkg;

	typedef logic [`AFU_LINE_W-1:0] line_t;      // one cache line
	typedef logic [`AFU_ADDR_W-1:0] line_addr_t; // host line address
	typedef logic [`AFU_TAG_W-1:0]  tag_t;       // request tag
	typedef logic [7:0]             mmio_addr_t; // csr byte offset
	typedef logic [63:0]            mmio_data_t;
	typedef logic [8:0]             mmio_tid_t;  // mmio transaction id

	typedef struct packed {
		logic       valid;
		logic       write; // 0 for read
		mmio_addr_t addr;
		mmio_data_t data;  // unused on reads
		mmio_tid_t  tid;
	} mmio_req_t;

	typedef struct packed {
		logic       valid;
		mmio_data_t data;
		mmio_tid_t  tid;   // echoes the request
	} mmio_rsp_t;

	typedef struct packed {
		logic       valid;
		line_addr_t addr;
		tag_t       tag;
	} host_rd_req_t;

	typedef struct packed {
		logic       valid;
		line_t      data;
		tag_t       tag;   // returned in request order
	} host_rd_rsp_t;

	typedef enum logic {
		WR_DATA = 1'b0,    // line write
		WR_IRQ  = 1'b1     // interrupt message
	} wr_kind_t;

	typedef struct packed {
		logic       valid;
		wr_kind_t   kind;
		line_addr_t addr;  // 0 for interrupts
		line_t      data;
		tag_t       tag;
	} host_wr_req_t;

	typedef struct packed {
		logic       valid;
		tag_t       tag;
	} host_wr_rsp_t;

endpackage

// ==== hw/host_rd_bridge.sv ====
// **********************************************************
// host read bridge
// engine line reads to credited host read requests,
// read data passed back to the engine unregistered
// **********************************************************
`timescale 1ns/10ps
`include "afu_params.svh"

module host_rd_bridge (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      line_req_valid,
	input  host_if_pkg::line_addr_t   line_req_addr,
	output logic                      line_req_ready,
	output logic                      line_data_valid,
	output host_if_pkg::line_t        line_data,
	output host_if_pkg::host_rd_req_t host_rd_req,
	input  host_if_pkg::host_rd_rsp_t host_rd_rsp,
	input  logic                      rd_credit      // one pulse per credit back
);

	localparam int CRED_W = $clog2(`AFU_RD_CREDITS + 1);
	typedef logic [CRED_W-1:0] cred_t;

	cred_t             credits;  // request slots left
	host_if_pkg::tag_t next_tag; // tag of next request
	host_if_pkg::tag_t exp_tag;  // tag the next return must carry
	logic              accept;

	assign line_req_ready  = credits != '0;
	assign accept          = line_req_valid & line_req_ready;
	assign line_data_valid = host_rd_rsp.valid; // in order, no reorder buffer
	assign line_data       = host_rd_rsp.data;

	always_ff @(posedge clk) begin
		host_rd_req.addr <= line_req_addr;
		host_rd_req.tag  <= next_tag;
		if (rst) begin
			host_rd_req.valid <= 1'b0;
			credits           <= cred_t'(`AFU_RD_CREDITS);
			next_tag          <= '0;
			exp_tag           <= '0;
		end else begin
			host_rd_req.valid <= accept;                                   // one cycle later
			credits           <= credits - cred_t'(accept) + cred_t'(rd_credit);
			if (accept)
				next_tag <= next_tag + host_if_pkg::tag_t'(1);
			if (host_rd_rsp.valid)
				exp_tag <= exp_tag + host_if_pkg::tag_t'(1);
		end
	end

	a_rd_in_order: assert property (@(posedge clk) disable iff (rst)
		host_rd_rsp.valid |-> host_rd_rsp.tag == exp_tag)
		else $error("read return tag %0d, expected %0d", host_rd_rsp.tag, exp_tag);

	a_rd_credit_max: assert property (@(posedge clk) disable iff (rst)
		credits <= cred_t'(`AFU_RD_CREDITS))
		else $error("host returned more read credits than it was given");

endmodule

// ==== hw/host_wr_bridge.sv ====
// **********************************************************
// host write bridge
// engine line writes and interrupt messages to credited
// host write requests, line acks passed back unregistered
// **********************************************************
`timescale 1ns/10ps
`include "afu_params.svh"

module host_wr_bridge (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      line_req_valid,
	input  host_if_pkg::line_addr_t   line_req_addr,
	input  host_if_pkg::line_t        line_req_data,
	output logic                      line_req_ready,
	input  logic                      irq_req,
	output logic                      irq_ready,
	output logic                      ack,          // line writes only
	output host_if_pkg::host_wr_req_t host_wr_req,
	input  host_if_pkg::host_wr_rsp_t host_wr_rsp,
	input  logic                      wr_credit
);

	localparam int CRED_W = $clog2(`AFU_WR_CREDITS + 1);
	typedef logic [CRED_W-1:0] cred_t;

	cred_t             credits;
	host_if_pkg::tag_t next_tag;
	host_if_pkg::tag_t irq_tag;  // tag of interrupt in flight
	logic              irq_pend;
	logic              data_acc;
	logic              irq_acc;
	logic              send;
	logic              irq_rsp;  // ack belongs to the interrupt

	assign line_req_ready = credits != '0;
	assign irq_ready      = line_req_ready & ~line_req_valid; // lines win
	assign data_acc       = line_req_valid & line_req_ready;
	assign irq_acc        = irq_req & irq_ready;
	assign send           = data_acc | irq_acc;
	assign irq_rsp        = host_wr_rsp.valid & irq_pend & (host_wr_rsp.tag == irq_tag);
	assign ack            = host_wr_rsp.valid & ~irq_rsp;

	always_ff @(posedge clk) begin
		host_wr_req.kind <= data_acc ? host_if_pkg::WR_DATA : host_if_pkg::WR_IRQ;
		host_wr_req.addr <= data_acc ? line_req_addr : '0;  // irq goes to 0
		host_wr_req.data <= data_acc ? line_req_data : '0;
		host_wr_req.tag  <= next_tag;
		if (irq_acc)
			irq_tag <= next_tag;
		if (rst) begin
			host_wr_req.valid <= 1'b0;
			credits           <= cred_t'(`AFU_WR_CREDITS);
			next_tag          <= '0;
			irq_pend          <= 1'b0;
		end else begin
			host_wr_req.valid <= send;
			credits           <= credits - cred_t'(send) + cred_t'(wr_credit);
			if (send)
				next_tag <= next_tag + host_if_pkg::tag_t'(1);
			if (irq_acc)
				irq_pend <= 1'b1;
			else if (irq_rsp)
				irq_pend <= 1'b0;
		end
	end

	// ack filter tracks a single interrupt
	a_wr_one_irq: assert property (@(posedge clk) disable iff (rst)
		irq_acc |-> !irq_pend)
		else $error("second interrupt sent before first was acked");

endmodule

// ==== hw/mmio_csr.sv ====
// **********************************************************
// mmio control registers
// decodes host mmio into copy descriptor and go pulse,
// answers reads one cycle later with the same tid
// **********************************************************
`timescale 1ns/10ps

module mmio_csr (
	input  logic                   clk,
	input  logic                   rst,
	input  host_if_pkg::mmio_req_t mmio_req,
	output host_if_pkg::mmio_rsp_t mmio_rsp,
	output dma_pkg::copy_desc_t    desc,       // to engine
	output logic                   start,      // one-cycle go
	input  logic                   busy,
	input  logic                   done,
	input  dma_pkg::len_t          lines_done
);

	dma_pkg::csr_addr_t reg_addr; // decoded offset
	dma_pkg::csr_data_t rd_data;  // read mux
	logic               wr_en;
	logic               rd_en;

	assign reg_addr = dma_pkg::csr_addr_t'(mmio_req.addr);
	assign wr_en    = mmio_req.valid & mmio_req.write;
	assign rd_en    = mmio_req.valid & ~mmio_req.write;

	// **********************************************************
	// register writes
	// **********************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			desc  <= '0;
			start <= 1'b0;
		end else begin
			start <= wr_en && reg_addr == dma_pkg::CSR_CTRL && mmio_req.data[0]; // go bit
			if (wr_en) begin
				case (reg_addr)
					dma_pkg::CSR_SRC:  desc.src    <= host_if_pkg::line_addr_t'(mmio_req.data);
					dma_pkg::CSR_DST:  desc.dst    <= host_if_pkg::line_addr_t'(mmio_req.data);
					dma_pkg::CSR_LEN:  desc.len    <= dma_pkg::len_t'(mmio_req.data);
					dma_pkg::CSR_CTRL: desc.irq_en <= mmio_req.data[1];
					default: ;                                 // status is read only
				endcase
			end
		end
	end

	// **********************************************************
	// read back
	// **********************************************************
	always_comb begin
		case (reg_addr)
			dma_pkg::CSR_SRC:    rd_data = dma_pkg::csr_data_t'(desc.src);
			dma_pkg::CSR_DST:    rd_data = dma_pkg::csr_data_t'(desc.dst);
			dma_pkg::CSR_LEN:    rd_data = dma_pkg::csr_data_t'(desc.len);
			dma_pkg::CSR_CTRL:   rd_data = dma_pkg::csr_data_t'({desc.irq_en, 1'b0}); // go reads 0
			dma_pkg::CSR_STATUS: rd_data = (dma_pkg::csr_data_t'(lines_done) << 16)  // bits 31:16
			                             | dma_pkg::csr_data_t'({done, busy});
			default:             rd_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		mmio_rsp.data <= rd_data;
		mmio_rsp.tid  <= mmio_req.tid;   // echo id
		if (rst)
			mmio_rsp.valid <= 1'b0;
		else
			mmio_rsp.valid <= rd_en;     // writes get no answer
	end

	a_mmio_addr_known: assert property (@(posedge clk) disable iff (rst)
		mmio_req.valid |-> reg_addr inside {dma_pkg::CSR_SRC, dma_pkg::CSR_DST,
			dma_pkg::CSR_LEN, dma_pkg::CSR_CTRL, dma_pkg::CSR_STATUS})
		else $error("mmio access to unmapped offset %h", mmio_req.addr);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the afu testbench with Verilator, run it and search the log for the pass line.
set -o pipefail
cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert -f afu.f --top-module tb_afu \
	-Mdir build/obj_dir -o sim_afu \
	&& ./build/obj_dir/sim_afu 2>&1 | tee build/sim.log \
	|| { echo "build or simulation failed"; exit 1; }

grep -qx "Finished with no errors" build/sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// ==== tb/host_mem_model.sv ====
// **********************************************************
// host memory model
// answers line reads in order two cycles after request,
// acks writes one cycle later, returns request credits
// after a fixed or random delay
// **********************************************************
`timescale 1ns/10ps

module tb_host_mem_model (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      stall,        // random credit delay
	input  host_if_pkg::host_rd_req_t host_rd_req,
	output host_if_pkg::host_rd_rsp_t host_rd_rsp,
	output logic                      rd_credit,
	input  host_if_pkg::host_wr_req_t host_wr_req,
	output host_if_pkg::host_wr_rsp_t host_wr_rsp,
	output logic                      wr_credit
);

	localparam int MEM_LINES = 2048;

	typedef struct packed {
		logic [31:0]        due;  // cycle to answer
		logic               irq;  // interrupt write
		host_if_pkg::line_t data;
		host_if_pkg::tag_t  tag;
	} pend_t;

	host_if_pkg::line_t        mem [MEM_LINES];
	pend_t                     rd_q [$];            // reads waiting for data return
	pend_t                     wr_q [$];            // writes waiting for ack
	logic [31:0]               rd_cq [$];           // credit return cycles
	logic [31:0]               wr_cq [$];
	logic [31:0]               cyc     = '0;
	logic [31:0]               rd_last = '0;        // keeps credit queue ordered
	logic [31:0]               wr_last = '0;
	integer                    seed    = 32'h0b6c_7ff4;
	int                        rd_req_count   = 0;
	int                        data_wr_count  = 0;
	int                        irq_count      = 0;
	int                        irq_nonzero    = 0;  // interrupts with address or data set
	int                        data_ack_count = 0;
	int                        acks_at_irq    = 0;  // data acks before last irq
	host_if_pkg::host_rd_rsp_t rd_rsp_q  = '0;
	host_if_pkg::host_wr_rsp_t wr_rsp_q  = '0;
	logic                      rd_cred_q = 1'b0;
	logic                      wr_cred_q = 1'b0;

	assign host_rd_rsp = rd_rsp_q;
	assign host_wr_rsp = wr_rsp_q;
	assign rd_credit   = rd_cred_q;
	assign wr_credit   = wr_cred_q;

	// everything on the falling edge, dut outputs are stable here
	always @(negedge clk) begin : serve
		logic [31:0] due;
		if (rst) begin
			for (int i = 0; i < MEM_LINES; i++)
				mem[i] = {32'(i) ^ 32'h3c5a_96e1, ~32'(i)}; // unique per line
			rd_q.delete();
			wr_q.delete();
			rd_cq.delete();
			wr_cq.delete();
			cyc            = '0;
			rd_last        = '0;
			wr_last        = '0;
			rd_req_count   = 0;
			data_wr_count  = 0;
			irq_count      = 0;
			irq_nonzero    = 0;
			data_ack_count = 0;
			acks_at_irq    = 0;
			rd_rsp_q       = '0;
			wr_rsp_q       = '0;
			rd_cred_q      = 1'b0;
			wr_cred_q      = 1'b0;
		end else begin
			cyc       = cyc + 32'd1;
			rd_rsp_q  = '0;
			wr_rsp_q  = '0;
			rd_cred_q = 1'b0;
			wr_cred_q = 1'b0;
			if (rd_q.size() != 0 && rd_q[0].due <= cyc) begin  // in order
				rd_rsp_q.valid = 1'b1;
				rd_rsp_q.data  = rd_q[0].data;
				rd_rsp_q.tag   = rd_q[0].tag;
				void'(rd_q.pop_front());
			end
			if (wr_q.size() != 0 && wr_q[0].due <= cyc) begin
				wr_rsp_q.valid = 1'b1;
				wr_rsp_q.tag   = wr_q[0].tag;
				if (!wr_q[0].irq)
					data_ack_count++;
				void'(wr_q.pop_front());
			end
			if (rd_cq.size() != 0 && rd_cq[0] <= cyc) begin    // one pulse per cycle
				rd_cred_q = 1'b1;
				void'(rd_cq.pop_front());
			end
			if (wr_cq.size() != 0 && wr_cq[0] <= cyc) begin
				wr_cred_q = 1'b1;
				void'(wr_cq.pop_front());
			end

			// **********************************************************
			// new requests
			// **********************************************************
			if (host_rd_req.valid) begin
				rd_q.push_back('{due: cyc + 32'd2, irq: 1'b0,
					data: mem[host_rd_req.addr[10:0]], tag: host_rd_req.tag});
				rd_req_count++;
				due = cyc + 32'd1;
				if (stall)
					due = due + ($unsigned($random(seed)) % 8);
				if (due < rd_last)
					due = rd_last;
				rd_last = due;
				rd_cq.push_back(due);
			end
			if (host_wr_req.valid) begin
				if (host_wr_req.kind == host_if_pkg::WR_IRQ) begin
					irq_count++;
					acks_at_irq = data_ack_count;
					if (host_wr_req.addr != '0 || host_wr_req.data != '0)
						irq_nonzero++;                        // message must be all zero
				end else begin
					mem[host_wr_req.addr[10:0]] = host_wr_req.data;
					data_wr_count++;
				end
				wr_q.push_back('{due: cyc + 32'd1, irq: host_wr_req.kind == host_if_pkg::WR_IRQ,
					data: '0, tag: host_wr_req.tag});
				due = cyc + 32'd1;
				if (stall)
					due = due + ($unsigned($random(seed)) % 8);
				if (due < wr_last)
					due = wr_last;
				wr_last = due;
				wr_cq.push_back(due);
			end
		end
	end

endmodule

// ==== tb/tb_afu.sv ====
// **********************************************************
// afu testbench
// mmio register access, line copies with and without credit
// stalls, interrupt message, busy and zero length runs
// **********************************************************
`timescale 1ns/10ps

module tb_afu;

	localparam int DONE_POLLS = 600; // status reads before giving up
	localparam int RSP_WAIT   = 8;   // cycles for a read response

	logic                      clk = 1'b0;
	logic                      rst;
	logic                      stall;
	host_if_pkg::mmio_req_t    mmio_req;
	host_if_pkg::mmio_rsp_t    mmio_rsp;
	host_if_pkg::host_rd_req_t host_rd_req;
	host_if_pkg::host_rd_rsp_t host_rd_rsp;
	logic                      rd_credit;
	host_if_pkg::host_wr_req_t host_wr_req;
	host_if_pkg::host_wr_rsp_t host_wr_rsp;
	logic                      wr_credit;
	string                     test_name;
	host_if_pkg::mmio_tid_t    next_tid;

	afu UUT (
		.clk         (clk),
		.rst         (rst),
		.mmio_req    (mmio_req),
		.mmio_rsp    (mmio_rsp),
		.host_rd_req (host_rd_req),
		.host_rd_rsp (host_rd_rsp),
		.rd_credit   (rd_credit),
		.host_wr_req (host_wr_req),
		.host_wr_rsp (host_wr_rsp),
		.wr_credit   (wr_credit)
	);

	tb_host_mem_model host (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.host_rd_req (host_rd_req),
		.host_rd_rsp (host_rd_rsp),
		.rd_credit   (rd_credit),
		.host_wr_req (host_wr_req),
		.host_wr_rsp (host_wr_rsp),
		.wr_credit   (wr_credit)
	);

	always #10 clk = ~clk; // 20 ns period

	// **********************************************************
	// failure reporting and compares
	// **********************************************************
	task abort_run;
		$display("Finished with errors");
		$fatal(1, "simulation stopped at first error");
	endtask

	task report_error(input string what);
		$display("ERROR in %s: %s", test_name, what);
		abort_run();
	endtask

	task check_csr(input dma_pkg::csr_data_t exp, input dma_pkg::csr_data_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %h, actual %h", test_name, exp, act);
			abort_run();
		end
	endtask

	task check_line(input host_if_pkg::line_t exp, input host_if_pkg::line_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %h, actual %h", test_name, exp, act);
			abort_run();
		end
	endtask

	task check_tid(input host_if_pkg::mmio_tid_t exp, input host_if_pkg::mmio_tid_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected tid %h, actual tid %h", test_name, exp, act);
			abort_run();
		end
	endtask

	task check_count(input int exp, input int act);
		if (act != exp) begin
			$display("CHECK FAILED %s: expected count %0d, actual count %0d", test_name, exp, act);
			abort_run();
		end
	endtask

	function automatic host_if_pkg::line_t mem_line(input host_if_pkg::line_addr_t a);
		return host.mem[a[10:0]]; // model memory, not the dut
	endfunction

	// **********************************************************
	// mmio access, driven on the falling edge
	// **********************************************************
	task mmio_write(input dma_pkg::csr_addr_t reg_addr, input dma_pkg::csr_data_t value);
		@(negedge clk);
		mmio_req.valid = 1'b1;
		mmio_req.write = 1'b1;
		mmio_req.addr  = host_if_pkg::mmio_addr_t'(reg_addr);
		mmio_req.data  = value;
		mmio_req.tid   = next_tid;
		next_tid       = next_tid + 9'd1;
		@(negedge clk);
		if (mmio_rsp.valid)
			report_error("mmio write was answered with a response");
		mmio_req = '0;
	endtask

	task mmio_read(input dma_pkg::csr_addr_t reg_addr, output dma_pkg::csr_data_t value);
		host_if_pkg::mmio_tid_t tid;
		int                     waited;
		@(negedge clk);
		tid            = next_tid;
		next_tid       = next_tid + 9'd1;
		mmio_req.valid = 1'b1;
		mmio_req.write = 1'b0;
		mmio_req.addr  = host_if_pkg::mmio_addr_t'(reg_addr);
		mmio_req.data  = '0;
		mmio_req.tid   = tid;
		@(negedge clk);
		mmio_req = '0;
		waited   = 1;
		while (!mmio_rsp.valid && waited < RSP_WAIT) begin
			@(negedge clk);
			waited++;
		end
		if (!mmio_rsp.valid)
			report_error("mmio read got no response");
		if (waited != 1)
			report_error("mmio read response came later than one cycle");
		check_tid(tid, mmio_rsp.tid);
		value = mmio_rsp.data;
	endtask

	task wait_done(output dma_pkg::csr_data_t status);
		int polls;
		polls = 0;
		mmio_read(dma_pkg::CSR_STATUS, status);
		while (!status[1] && polls < DONE_POLLS) begin
			mmio_read(dma_pkg::CSR_STATUS, status);
			polls++;
		end
		if (!status[1])
			report_error("copy did not report done in time");
	endtask

	// one whole copy run, destination checked against the old source
	task run_copy(input host_if_pkg::line_addr_t src, input host_if_pkg::line_addr_t dst,
	              input dma_pkg::len_t len, input logic irq_en, input logic probe_busy);
		host_if_pkg::line_t expect_lines [$];
		host_if_pkg::line_t below;
		host_if_pkg::line_t above;
		dma_pkg::csr_data_t status;
		int                 i;
		expect_lines = {};
		for (i = 0; i < int'(len); i++)
			expect_lines.push_back(mem_line(src + host_if_pkg::line_addr_t'(i)));
		below = mem_line(dst - 32'd1);
		above = mem_line(dst + host_if_pkg::line_addr_t'(len));
		mmio_write(dma_pkg::CSR_SRC, dma_pkg::csr_data_t'(src));
		mmio_write(dma_pkg::CSR_DST, dma_pkg::csr_data_t'(dst));
		mmio_write(dma_pkg::CSR_LEN, dma_pkg::csr_data_t'(len));
		mmio_write(dma_pkg::CSR_CTRL, {62'd0, irq_en, 1'b1}); // go
		if (probe_busy) begin
			mmio_read(dma_pkg::CSR_STATUS, status);
			check_csr(64'h1, status & 64'h3);                   // busy, not done
			mmio_write(dma_pkg::CSR_CTRL, 64'h1);               // second go
		end
		wait_done(status);
		check_csr((dma_pkg::csr_data_t'(len) << 16) | 64'h2, status);
		for (i = 0; i < int'(len); i++)
			check_line(expect_lines[i], mem_line(dst + host_if_pkg::line_addr_t'(i)));
		check_line(below, mem_line(dst - 32'd1));               // neighbours untouched
		check_line(above, mem_line(dst + host_if_pkg::line_addr_t'(len)));
	endtask

	// **********************************************************
	// directed tests
	// **********************************************************
	task reset_readback;
		dma_pkg::csr_data_t value;
		test_name = "reset_readback";
		mmio_read(dma_pkg::CSR_STATUS, value);
		check_csr(64'h0, value);
		mmio_write(dma_pkg::CSR_SRC, 64'h0000_0000_dead_beef);
		mmio_write(dma_pkg::CSR_DST, 64'h0000_0000_0bad_f00d);
		mmio_write(dma_pkg::CSR_LEN, 64'h0000_0000_0000_1234);
		mmio_read(dma_pkg::CSR_SRC, value);
		check_csr(64'h0000_0000_dead_beef, value);
		mmio_read(dma_pkg::CSR_DST, value);
		check_csr(64'h0000_0000_0bad_f00d, value);
		mmio_read(dma_pkg::CSR_LEN, value);
		check_csr(64'h0000_0000_0000_1234, value);
	endtask

	task basic_copy;
		test_name = "basic_copy";
		run_copy(32'h040, 32'h050, 16'd5, 1'b0, 1'b0);
	endtask

	task copy_under_stalls;
		test_name = "copy_under_stalls";
		@(negedge clk);
		stall = 1'b1;
		run_copy(32'h100, 32'h180, 16'd20, 1'b0, 1'b0);
		@(negedge clk);
		stall = 1'b0;
	endtask

	task interrupt_message;
		int                 irqs;
		int                 acks;
		dma_pkg::csr_data_t status;
		test_name = "interrupt_enabled";
		irqs = host.irq_count;
		acks = host.data_ack_count;
		run_copy(32'h200, 32'h280, 16'd4, 1'b1, 1'b0);
		check_count(irqs + 1, host.irq_count);
		check_count(acks + 4, host.acks_at_irq);                // all data acks first
		check_count(acks + 4, host.data_ack_count);
		check_count(0, host.irq_nonzero);                       // address 0, data 0
		mmio_read(dma_pkg::CSR_STATUS, status);
		check_csr(64'h0000_0000_0004_0002, status);             // irq ack is not a line
		test_name = "interrupt_disabled";
		irqs = host.irq_count;
		run_copy(32'h200, 32'h2c0, 16'd4, 1'b0, 1'b0);
		check_count(irqs, host.irq_count);
	endtask

	task busy_and_zero_length;
		int reads;
		int writes;
		int irqs;
		test_name = "busy_restart";
		reads  = host.rd_req_count;
		writes = host.data_wr_count;
		run_copy(32'h300, 32'h380, 16'd100, 1'b0, 1'b1);
		check_count(reads + 100, host.rd_req_count);            // no second run
		check_count(writes + 100, host.data_wr_count);
		test_name = "zero_length";
		reads  = host.rd_req_count;
		writes = host.data_wr_count;
		irqs   = host.irq_count;
		run_copy(32'h020, 32'h030, 16'd0, 1'b0, 1'b0);
		check_count(reads, host.rd_req_count);
		check_count(writes, host.data_wr_count);
		check_count(irqs, host.irq_count);
	endtask

	initial begin
		rst       = 1'b1;
		stall     = 1'b0;
		mmio_req  = '0;
		next_tid  = '0;
		test_name = "reset";
		repeat (3) @(negedge clk);
		rst = 1'b0;
		reset_readback();
		basic_copy();
		copy_under_stalls();
		interrupt_message();
		busy_and_zero_length();
		$display("Finished with no errors");
		$finish;
	end

endmodule
